// File: compile.f
logic/cpu_pkg.sv
logic/pc_unit.sv
logic/register_file.sv
logic/alu_unit.sv
logic/memory_interface.sv
logic/cpu_datapath.sv
verification/cpu_datapath_tb.sv

// File: logic/alu_unit.sv
`timescale 1ns/10ps

module alu_unit
	import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input datapath_ctrl_t ctrl,
	input alu_select_t alu_select,
	input word_t pc,
	input word_t rf_a,
	input word_t rf_b,
	input word_t constant_c,
	output word_t alu_z,
	output word_t hi,
	output word_t lo
);

	word_t op_a;
	word_t op_b;
	word_t quotient;
	word_t remainder;
	word_t hi_result;
	word_t lo_result;
	logic signed [31:0] op_a_s;
	logic signed [31:0] op_b_s;
	logic signed [63:0] product;
	logic [63:0] ror_wide;
	logic [63:0] rol_wide;
	logic [4:0] shamt;

	// Operand A from register A or PC
	always_comb begin
		case ({ctrl.alu_a_in_rf, ctrl.alu_a_in_pc})
			2'b10: op_a = rf_a;
			2'b01: op_a = pc;
			default: op_a = '0;
		endcase
	end

	// Operand B from register B or the constant
	always_comb begin
		case ({ctrl.alu_b_in_rf, ctrl.alu_b_in_constant})
			2'b10: op_b = rf_b;
			2'b01: op_b = constant_c;
			default: op_b = '0;
		endcase
	end

	assign op_a_s = op_a;
	assign op_b_s = op_b;
	assign shamt = op_b[4:0];

	// Rotates from a doubled word
	assign ror_wide = {op_a, op_a} >> shamt;
	assign rol_wide = {op_a, op_a} << shamt;

	assign product = op_a_s * op_b_s;

	always_comb begin
		if (op_b == '0) begin
			quotient = '0;
			remainder = op_a;
		end else begin
			quotient = word_t'(op_a_s / op_b_s);
			remainder = word_t'(op_a_s % op_b_s);
		end
	end

	// Anything not one-hot gives zero everywhere
	always_comb begin
		alu_z = '0;
		hi_result = '0;
		lo_result = '0;
		case (alu_select)
			alu_select_t'(1 << alu_sel_add): alu_z = op_a + op_b;
			alu_select_t'(1 << alu_sel_sub): alu_z = op_a - op_b;
			alu_select_t'(1 << alu_sel_shr): alu_z = op_a >> shamt;
			alu_select_t'(1 << alu_sel_shl): alu_z = op_a << shamt;
			alu_select_t'(1 << alu_sel_ror): alu_z = ror_wide[31:0];
			alu_select_t'(1 << alu_sel_rol): alu_z = rol_wide[63:32];
			alu_select_t'(1 << alu_sel_and): alu_z = op_a & op_b;
			alu_select_t'(1 << alu_sel_or): alu_z = op_a | op_b;
			alu_select_t'(1 << alu_sel_mul): begin
				hi_result = product[63:32];
				lo_result = product[31:0];
			end
			alu_select_t'(1 << alu_sel_div): begin
				hi_result = remainder;
				lo_result = quotient;
			end
			alu_select_t'(1 << alu_sel_neg): alu_z = -op_a;
			alu_select_t'(1 << alu_sel_not): alu_z = ~op_a;
			default: alu_z = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			hi <= '0;
			lo <= '0;
		end else begin
			if (ctrl.hi_en) begin
				hi <= hi_result;
			end
			if (ctrl.lo_en) begin
				lo <= lo_result;
			end
		end
	end

endmodule

// File: logic/cpu_datapath.sv
`timescale 1ns/10ps

module cpu_datapath
	import cpu_pkg::*;
#(
	parameter int mem_depth = 512
) (
	input logic clk,
	input logic reset,
	input datapath_ctrl_t ctrl,
	input rf_addr_t rf_addr,
	input alu_select_t alu_select,
	input word_t constant_c,
	output word_t ir_out
);

	// Three-bus datapath word buses
	word_t pc;
	word_t rf_a;
	word_t rf_b;
	word_t alu_z;
	word_t hi;
	word_t lo;
	word_t md;

	pc_unit u_pc_unit (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.alu_z(alu_z),
		.rf_a(rf_a),
		.pc(pc)
	);

	register_file u_register_file (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.rf_addr(rf_addr),
		.alu_z(alu_z),
		.hi(hi),
		.lo(lo),
		.md(md),
		.rf_a(rf_a),
		.rf_b(rf_b)
	);

	alu_unit u_alu_unit (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.alu_select(alu_select),
		.pc(pc),
		.rf_a(rf_a),
		.rf_b(rf_b),
		.constant_c(constant_c),
		.alu_z(alu_z),
		.hi(hi),
		.lo(lo)
	);

	// IR is the only register seen from outside
	memory_interface #(
		.mem_depth(mem_depth)
	) u_memory_interface (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.pc(pc),
		.alu_z(alu_z),
		.rf_b(rf_b),
		.md(md),
		.ir(ir_out)
	);

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_addr_t;
	typedef logic [11:0] alu_select_t;

	// Datapath sizing
	localparam int num_regs = 16;
	localparam word_t pc_step = 32'd4;
	localparam int word_bytes = 4;

	// Bit positions in the one-hot ALU select
	localparam int alu_sel_add = 0;
	localparam int alu_sel_sub = 1;
	localparam int alu_sel_shr = 2;
	localparam int alu_sel_shl = 3;
	localparam int alu_sel_ror = 4;
	localparam int alu_sel_rol = 5;
	localparam int alu_sel_and = 6;
	localparam int alu_sel_or = 7;
	localparam int alu_sel_mul = 8;
	localparam int alu_sel_div = 9;
	localparam int alu_sel_neg = 10;
	localparam int alu_sel_not = 11;

	// Strobes from the outside controller, one transfer per clock
	typedef struct packed {
		logic ir_en;
		// PC sources
		logic pc_increment;
		logic pc_in_alu;
		logic pc_in_rf_a;
		// MA sources
		logic ma_in_pc;
		logic ma_in_alu;
		// MD sources
		logic md_in_memory;
		logic md_in_rf_b;
		// ALU operand sources
		logic alu_a_in_rf;
		logic alu_a_in_pc;
		logic alu_b_in_rf;
		logic alu_b_in_constant;
		logic hi_en;
		logic lo_en;
		// Register file write sources
		logic rf_in_alu;
		logic rf_in_hi;
		logic rf_in_lo;
		logic rf_in_md;
		logic mem_write;
	} datapath_ctrl_t;

	// Two read ports and the write port
	typedef struct packed {
		reg_addr_t a;
		reg_addr_t b;
		reg_addr_t z;
	} rf_addr_t;

endpackage

// File: logic/memory_interface.sv
`timescale 1ns/10ps

module memory_interface
	import cpu_pkg::*;
#(
	parameter int mem_depth = 512
) (
	input logic clk,
	input logic reset,
	input datapath_ctrl_t ctrl,
	input word_t pc,
	input word_t alu_z,
	input word_t rf_b,
	output word_t md,
	output word_t ir
);

	localparam int index_bits = $clog2(mem_depth);
	localparam int offset_bits = $clog2(word_bytes);

	word_t mem_array [mem_depth];
	word_t ma;
	word_t ma_next;
	word_t md_next;
	word_t mem_read;
	logic ma_load;
	logic md_load;
	logic [index_bits-1:0] mem_index;

	// Word index, byte offset and bits above the depth dropped
	assign mem_index = ma[offset_bits +: index_bits];
	assign mem_read = mem_array[mem_index];

	assign ma_load = ctrl.ma_in_pc | ctrl.ma_in_alu;
	assign md_load = ctrl.md_in_memory | ctrl.md_in_rf_b;

	always_comb begin
		case ({ctrl.ma_in_pc, ctrl.ma_in_alu})
			2'b10: ma_next = pc;
			2'b01: ma_next = alu_z;
			default: ma_next = '0;
		endcase
	end

	always_comb begin
		case ({ctrl.md_in_memory, ctrl.md_in_rf_b})
			2'b10: md_next = mem_read;
			2'b01: md_next = rf_b;
			default: md_next = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ma <= '0;
			md <= '0;
			ir <= '0;
		end else begin
			if (ma_load) begin
				ma <= ma_next;
			end
			if (md_load) begin
				md <= md_next;
			end
			// IR takes MD as it stood this cycle
			if (ctrl.ir_en) begin
				ir <= md;
			end
		end
	end

	// Store uses the current MA and MD
	always_ff @(posedge clk) begin
		if (ctrl.mem_write) begin
			mem_array[mem_index] <= md;
		end
	end

endmodule

// File: logic/pc_unit.sv
`timescale 1ns/10ps

module pc_unit
	import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input datapath_ctrl_t ctrl,
	input word_t alu_z,
	input word_t rf_a,
	output word_t pc
);

	word_t pc_next;
	logic pc_load;

	// Any PC strobe loads, none holds
	assign pc_load = ctrl.pc_increment | ctrl.pc_in_alu | ctrl.pc_in_rf_a;

	// Conflicting strobes load zero
	always_comb begin
		case ({ctrl.pc_increment, ctrl.pc_in_alu, ctrl.pc_in_rf_a})
			3'b100: pc_next = pc + pc_step;
			3'b010: pc_next = alu_z;
			3'b001: pc_next = rf_a;
			default: pc_next = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (pc_load) begin
			pc <= pc_next;
		end
	end

endmodule

// File: logic/register_file.sv
`timescale 1ns/10ps

module register_file
	import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input datapath_ctrl_t ctrl,
	input rf_addr_t rf_addr,
	input word_t alu_z,
	input word_t hi,
	input word_t lo,
	input word_t md,
	output word_t rf_a,
	output word_t rf_b
);

	word_t regs [num_regs];
	word_t write_data;
	logic write_en;

	assign write_en = ctrl.rf_in_alu | ctrl.rf_in_hi | ctrl.rf_in_lo | ctrl.rf_in_md;

	always_comb begin
		case ({ctrl.rf_in_alu, ctrl.rf_in_hi, ctrl.rf_in_lo, ctrl.rf_in_md})
			4'b1000: write_data = alu_z;
			4'b0100: write_data = hi;
			4'b0010: write_data = lo;
			4'b0001: write_data = md;
			default: write_data = '0;
		endcase
	end

	// r0 reads as zero
	assign rf_a = (rf_addr.a == '0) ? '0 : regs[rf_addr.a];
	assign rf_b = (rf_addr.b == '0) ? '0 : regs[rf_addr.b];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && rf_addr.z != '0) begin
			regs[rf_addr.z] <= write_data;
		end
	end

endmodule

// File: verification/cpu_datapath_tb.sv
`timescale 1ns/10ps

module cpu_datapath_tb
	import cpu_pkg::*;
;

	localparam int mem_depth = 512;
	localparam int clk_period = 10;
	localparam int reset_cycles = 5;
	localparam int op_rounds = 4;
	localparam int muldiv_rounds = 4;
	localparam int pc_steps = 7;
	localparam int mem_words = 8;

	// Transfers per test section, used to size the watchdog
	localparam int reset_transfers = reset_cycles + num_regs * 3;
	localparam int regfile_transfers = num_regs + num_regs * 3;
	localparam int alu_transfers = op_rounds * 10 * 10 + 4;
	localparam int muldiv_transfers = (2 * muldiv_rounds + 1) * 11;
	localparam int pc_transfers = pc_steps + 4 + 5 + 6;
	localparam int mem_transfers = mem_words * 11 + 5;
	localparam int total_transfers = reset_transfers + regfile_transfers + alu_transfers
		+ muldiv_transfers + pc_transfers + mem_transfers;

	logic clk = 1'b0;
	logic reset;
	datapath_ctrl_t ctrl;
	rf_addr_t rf_addr;
	alu_select_t alu_select;
	word_t constant_c;
	word_t ir_out;

	int error_count = 0;
	word_t lfsr_state = 32'h1206_9194;
	word_t reg_values [num_regs];
	word_t mem_model [mem_depth];
	int unsigned word_index [mem_words];
	word_t op_a;
	word_t op_b;
	word_t op_c;
	word_t pc_value;
	int single_ops [10] = '{alu_sel_add, alu_sel_sub, alu_sel_shr, alu_sel_shl, alu_sel_ror,
		alu_sel_rol, alu_sel_and, alu_sel_or, alu_sel_neg, alu_sel_not};

	cpu_datapath #(
		.mem_depth(mem_depth)
	) DUT (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.rf_addr(rf_addr),
		.alu_select(alu_select),
		.constant_c(constant_c),
		.ir_out(ir_out)
	);

	always #(clk_period / 2) clk = ~clk;

	// Taps 32, 22, 2 and 1
	function automatic word_t random_bits(input int count);
		word_t value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	// Single-result ALU rules
	function automatic word_t alu_expected(input int op, input word_t a, input word_t b);
		int unsigned amount;
		amount = b[4:0];
		case (op)
			alu_sel_add: return a + b;
			alu_sel_sub: return a - b;
			alu_sel_shr: return a >> amount;
			alu_sel_shl: return a << amount;
			alu_sel_ror: return (amount == 0) ? a : ((a >> amount) | (a << (32 - amount)));
			alu_sel_rol: return (amount == 0) ? a : ((a << amount) | (a >> (32 - amount)));
			alu_sel_and: return a & b;
			alu_sel_or: return a | b;
			alu_sel_neg: return ~a + 32'd1;
			alu_sel_not: return ~a;
			default: return '0;
		endcase
	endfunction

	// Returns {hi, lo}
	function automatic logic [63:0] muldiv_expected(input int op, input word_t a, input word_t b);
		int sa;
		int sb;
		longint product;
		int quotient;
		int remainder;
		sa = a;
		sb = b;
		if (op == alu_sel_mul) begin
			product = longint'(sa) * longint'(sb);
			return product;
		end
		if (sb == 0) begin
			return {a, 32'h0};
		end
		quotient = sa / sb;
		remainder = sa % sb;
		return {remainder, quotient};
	endfunction

	// Strobes fall back to zero every cycle
	task automatic begin_cycle();
		@(posedge clk);
		#1;
		ctrl = '0;
		rf_addr = '0;
		alu_select = '0;
		constant_c = '0;
	endtask

	task automatic check_ir(input string what, input word_t expected);
		assert (ir_out === expected)
		else begin
			error_count++;
			$display("[FAIL] ir_out (%s) expected %h got %h", what, expected, ir_out);
		end
	endtask

	// Register B to MD, MD to IR
	task automatic read_register(input reg_addr_t r, input word_t expected, input string what);
		begin_cycle();
		rf_addr.b = r;
		ctrl.md_in_rf_b = 1'b1;
		begin_cycle();
		ctrl.ir_en = 1'b1;
		begin_cycle();
		check_ir($sformatf("%s r%0d", what, r), expected);
	endtask

	task automatic load_constant(input reg_addr_t r, input word_t value);
		begin_cycle();
		constant_c = value;
		ctrl.alu_b_in_constant = 1'b1;
		alu_select = alu_select_t'(12'd1 << alu_sel_add);
		ctrl.rf_in_alu = 1'b1;
		rf_addr.z = r;
	endtask

	task automatic run_alu(input alu_select_t sel, input logic use_constant, input word_t c,
		input reg_addr_t rd);
		begin_cycle();
		rf_addr.a = 4'd1;
		rf_addr.b = 4'd2;
		rf_addr.z = rd;
		ctrl.alu_a_in_rf = 1'b1;
		if (use_constant) begin
			ctrl.alu_b_in_constant = 1'b1;
			constant_c = c;
		end else begin
			ctrl.alu_b_in_rf = 1'b1;
		end
		alu_select = sel;
		ctrl.rf_in_alu = 1'b1;
	endtask

	task automatic check_muldiv(input int op, input word_t a, input word_t b);
		logic [63:0] expected;
		expected = muldiv_expected(op, a, b);
		load_constant(4'd1, a);
		load_constant(4'd2, b);
		begin_cycle();
		rf_addr.a = 4'd1;
		rf_addr.b = 4'd2;
		ctrl.alu_a_in_rf = 1'b1;
		ctrl.alu_b_in_rf = 1'b1;
		alu_select = alu_select_t'(12'd1 << op);
		ctrl.hi_en = 1'b1;
		ctrl.lo_en = 1'b1;
		begin_cycle();
		ctrl.rf_in_hi = 1'b1;
		rf_addr.z = 4'd5;
		begin_cycle();
		ctrl.rf_in_lo = 1'b1;
		rf_addr.z = 4'd6;
		read_register(4'd5, expected[63:32], $sformatf("hi of op %0d", op));
		read_register(4'd6, expected[31:0], $sformatf("lo of op %0d", op));
	endtask

	// PC plus zero into r8, then out through IR
	task automatic read_pc(input word_t expected, input string what);
		begin_cycle();
		ctrl.alu_a_in_pc = 1'b1;
		ctrl.alu_b_in_constant = 1'b1;
		alu_select = alu_select_t'(12'd1 << alu_sel_add);
		ctrl.rf_in_alu = 1'b1;
		rf_addr.z = 4'd8;
		read_register(4'd8, expected, what);
	endtask

	task automatic store_word(input word_t addr, input word_t data);
		load_constant(4'd7, data);
		begin_cycle();
		constant_c = addr;
		ctrl.alu_b_in_constant = 1'b1;
		alu_select = alu_select_t'(12'd1 << alu_sel_add);
		ctrl.ma_in_alu = 1'b1;
		begin_cycle();
		rf_addr.b = 4'd7;
		ctrl.md_in_rf_b = 1'b1;
		begin_cycle();
		ctrl.mem_write = 1'b1;
	endtask

	task automatic load_word(input int unsigned index, input word_t expected);
		begin_cycle();
		constant_c = index * word_bytes;
		ctrl.alu_b_in_constant = 1'b1;
		alu_select = alu_select_t'(12'd1 << alu_sel_add);
		ctrl.ma_in_alu = 1'b1;
		begin_cycle();
		ctrl.md_in_memory = 1'b1;
		begin_cycle();
		// MD into IR and r10 together
		ctrl.ir_en = 1'b1;
		ctrl.rf_in_md = 1'b1;
		rf_addr.z = 4'd10;
		begin_cycle();
		check_ir($sformatf("memory word %0d", index), expected);
		read_register(4'd10, expected, "memory to register");
	endtask

	initial begin
		ctrl = '0;
		rf_addr = '0;
		alu_select = '0;
		constant_c = '0;
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;
		check_ir("after reset", '0);
		for (int r = 0; r < num_regs; r++) begin
			read_register(reg_addr_t'(r), '0, "reset");
		end

		// r0 must ignore its write
		for (int r = 1; r < num_regs; r++) begin
			reg_values[r] = random_bits(32);
			load_constant(reg_addr_t'(r), reg_values[r]);
		end
		load_constant(4'd0, random_bits(32));
		reg_values[0] = '0;
		for (int r = 0; r < num_regs; r++) begin
			read_register(reg_addr_t'(r), reg_values[r], "register file");
		end

		for (int k = 0; k < 10; k++) begin
			for (int n = 0; n < op_rounds; n++) begin
				op_a = random_bits(32);
				op_b = random_bits(32);
				op_c = random_bits(32);
				load_constant(4'd1, op_a);
				load_constant(4'd2, op_b);
				run_alu(alu_select_t'(12'd1 << single_ops[k]), 1'b0, '0, 4'd3);
				read_register(4'd3, alu_expected(single_ops[k], op_a, op_b), "alu reg");
				run_alu(alu_select_t'(12'd1 << single_ops[k]), 1'b1, op_c, 4'd4);
				read_register(4'd4, alu_expected(single_ops[k], op_a, op_c), "alu constant");
			end
		end
		// Two-bit select
		run_alu(alu_select_t'((12'd1 << alu_sel_add) | (12'd1 << alu_sel_sub)), 1'b0, '0, 4'd3);
		read_register(4'd3, '0, "two-bit select");

		for (int n = 0; n < muldiv_rounds; n++) begin
			check_muldiv(alu_sel_mul, random_bits(32), random_bits(32));
			check_muldiv(alu_sel_div, random_bits(32), random_bits(32) >> random_bits(4));
		end
		check_muldiv(alu_sel_div, random_bits(32), '0);

		repeat (pc_steps) begin
			begin_cycle();
			ctrl.pc_increment = 1'b1;
		end
		read_pc(pc_step * pc_steps, "pc increment");
		pc_value = random_bits(32);
		begin_cycle();
		constant_c = pc_value;
		ctrl.alu_b_in_constant = 1'b1;
		alu_select = alu_select_t'(12'd1 << alu_sel_add);
		ctrl.pc_in_alu = 1'b1;
		read_pc(pc_value, "pc from alu");
		pc_value = random_bits(32);
		load_constant(4'd9, pc_value);
		begin_cycle();
		rf_addr.a = 4'd9;
		ctrl.pc_in_rf_a = 1'b1;
		read_pc(pc_value, "pc from register a");

		// Store addresses carry random byte offset and upper bits
		for (int n = 0; n < mem_words; n++) begin
			op_a = random_bits(32);
			op_b = random_bits(32);
			word_index[n] = (op_a / word_bytes) % mem_depth;
			mem_model[word_index[n]] = op_b;
			store_word(op_a, op_b);
		end
		for (int n = 0; n < mem_words; n++) begin
			load_word(word_index[n], mem_model[word_index[n]]);
		end

		// Fetch of the first stored word with MA taken from the PC
		begin_cycle();
		constant_c = word_index[0] * word_bytes;
		ctrl.alu_b_in_constant = 1'b1;
		alu_select = alu_select_t'(12'd1 << alu_sel_add);
		ctrl.pc_in_alu = 1'b1;
		begin_cycle();
		ctrl.ma_in_pc = 1'b1;
		begin_cycle();
		ctrl.md_in_memory = 1'b1;
		begin_cycle();
		ctrl.ir_en = 1'b1;
		begin_cycle();
		check_ir("fetch at pc", mem_model[word_index[0]]);

		$display("Run finished with %0d errors", error_count);
		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(2 * total_transfers * clk_period);
		$display("Run timed out before all transfers finished");
		$display("Test failed");
		$finish;
	end

endmodule
